//--- vlog.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_byte_if.sv
hw/wb_reg_if.sv
hw/spi_slave.sv
hw/spi_wb_bridge.sv
hw/spi_reg_file.sv
hw/spi_target_top.sv
testbench/spi_target_checker.sv
testbench/tb_spi_target.sv

//--- Bender.yml
package:
  name: spi_target
sources:
  - include_dirs:
      - hw
    files:
      - hw/spi_pkg.sv
      - hw/spi_byte_if.sv
      - hw/wb_reg_if.sv
      - hw/spi_slave.sv
      - hw/spi_wb_bridge.sv
      - hw/spi_reg_file.sv
      - hw/spi_target_top.sv
      - testbench/spi_target_checker.sv
      - testbench/tb_spi_target.sv

//--- testbench/tb_spi_target.sv
////////////////////////////////////////////////////////////////////////////
// Mode 3 SPI master at the fastest legal SCLK. Storage registers have
// no reset value, so a register is only read back after it was written.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "spi_params.svh"

module tb_spi_target;

	localparam int HALF    = `SPI_MIN_HALF_CYC;  // sclk half period, cycles
	localparam int FRAME_W = 2 * `SPI_DATA_W;

	logic                   sys_clk = 1'b0;
	logic                   sys_rst_n;
	logic                   cs_n;
	logic                   sclk;
	logic                   mosi;
	logic                   miso;
	logic [`SPI_DATA_W-1:0] gpio_out;
	spi_pkg::reg_data_t     ref_regs [`SPI_NUM_REGS];  // expected register contents
	int unsigned            cycle_cnt = 0;

	spi_target_top spi_target_top_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs_n      (cs_n),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.gpio_out  (gpio_out)
	);
	bind spi_target_top spi_target_checker checker_inst (.*);
	always #10 sys_clk = ~sys_clk;

	task automatic fail_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check_byte(input string name, input spi_pkg::reg_data_t got, exp);
		assert (got === exp)
		else begin
			$display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
			fail_run("wrong value");
		end
	endtask

	// one frame, nbits below FRAME_W raises cs_n early
	task automatic spi_access(input logic write, input spi_pkg::reg_addr_t addr,
			input spi_pkg::reg_data_t data, input logic [2:0] rsvd, input int nbits);
		spi_pkg::cmd_t      cmd;
		logic [FRAME_W-1:0] tx;
		spi_pkg::reg_data_t rd;
		cmd  = '{write, rsvd, addr};
		tx   = {cmd, data};
		rd   = '0;
		cs_n = 1'b0;
		repeat (HALF) @(negedge sys_clk);
		for (int i = FRAME_W - 1; i >= FRAME_W - nbits; i--) begin
			sclk = 1'b0;                        // leading edge, target shifts
			mosi = tx[i];
			repeat (HALF) @(negedge sys_clk);
			sclk = 1'b1;                        // trailing edge, both sides sample
			rd   = {rd[`SPI_DATA_W-2:0], miso};
			repeat (HALF) @(negedge sys_clk);
		end
		if (write && nbits == FRAME_W && addr != '0)
			ref_regs[addr] = data;              // register 0 is read only
		if (!write)
			check_byte($sformatf("miso reg%0d", addr), rd, ref_regs[addr]);
		check_byte("gpio_out", gpio_out, ref_regs[`SPI_GPIO_REG]);  // cs_n still low
		cs_n = 1'b1;
		mosi = 1'b0;
		repeat (2 * HALF) @(negedge sys_clk);
	endtask

	initial begin
		spi_pkg::reg_addr_t addr;
		void'($urandom(32'hc9de_106e));
		sys_rst_n = 1'b0;
		cs_n      = 1'b1;
		sclk      = 1'b1;                       // mode 3 idles high
		mosi      = 1'b0;
		ref_regs[0]             = `SPI_DEV_ID;
		ref_regs[`SPI_GPIO_REG] = '0;
		repeat (8) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		spi_access(1'b0, 4'd0, 8'h00, 3'b000, FRAME_W);       // id, gpio still 0
		repeat (30) begin
			addr = spi_pkg::reg_addr_t'($urandom_range(`SPI_NUM_REGS - 1, 2));
			spi_access(1'b1, addr, spi_pkg::reg_data_t'($urandom), 3'b000, FRAME_W);
			spi_access(1'b0, addr, 8'h00, 3'b000, FRAME_W);
		end
		spi_access(1'b1, `SPI_GPIO_REG, 8'h69, 3'b000, FRAME_W);  // pins follow
		spi_access(1'b0, `SPI_GPIO_REG, 8'h00, 3'b000, FRAME_W);
		spi_access(1'b1, 4'd0, 8'h3c, 3'b000, FRAME_W);       // write to id dropped
		spi_access(1'b0, 4'd0, 8'h00, 3'b000, FRAME_W);
		spi_access(1'b1, 4'd7, 8'h3c, 3'b000, FRAME_W);
		spi_access(1'b1, 4'd7, 8'hc3, 3'b000, FRAME_W - 4);   // cut mid data byte
		spi_access(1'b0, 4'd7, 8'h00, 3'b000, FRAME_W);
		spi_access(1'b1, 4'd7, 8'h5a, 3'b000, FRAME_W);
		spi_access(1'b0, 4'd7, 8'h00, 3'b000, FRAME_W);
		spi_access(1'b1, 4'd9, 8'hd2, 3'b101, FRAME_W);       // reserved bits set
		spi_access(1'b0, 4'd9, 8'h00, 3'b010, FRAME_W);
		if (spi_target_top_inst.checker_inst.err_cnt != 0)
			fail_run("a bound protocol assertion failed");
		else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= 30000)                 // 72 frames of about 280 cycles
			fail_run("timeout, the test did not finish");
		else if (spi_target_top_inst.checker_inst.err_cnt != 0)
			fail_run("a bound protocol assertion failed");
	end

endmodule

//--- testbench/spi_target_checker.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic and byte strobe checks, bound into spi_target_top.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_target_checker (
	input logic sys_clk,
	input logic sys_rst_n,
	wb_reg_if   wb,
	spi_byte_if byte_io
);

	int unsigned err_cnt = 0;   // failed assertions so far
	function automatic void count_failure(input string what);
		err_cnt++;
		$error("%s", what);
	endfunction

	stb_in_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb.stb |-> wb.cyc) else count_failure("stb high outside a bus cycle");
	ack_with_stb: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb.ack |-> wb.stb) else count_failure("ack without stb");
	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb.ack |=> !wb.ack) else count_failure("ack held longer than one cycle");
	req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb.stb && !wb.ack |=> wb.stb && $stable(wb.adr) && $stable(wb.we))
		else count_failure("stb, adr or we changed before ack");
	quiet_in_reset: assert property (@(posedge sys_clk)
		!sys_rst_n |=> !byte_io.rx_valid && !byte_io.frame_end)
		else count_failure("byte strobe active during reset");

endmodule

//--- hw/spi_target_top.sv
////////////////////////////////////////////////////////////////////////////
// SPI register target, mode set by SPI_CPOL / SPI_CPHA. Two-byte frames,
// later bytes ignored. miso is driven low, not tri-stated, when idle.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_target_top (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   cs_n,
	input  logic                   sclk,
	input  logic                   mosi,
	output logic                   miso,
	output logic [`SPI_DATA_W-1:0] gpio_out
);

	spi_byte_if byte_io ();
	wb_reg_if   wb ();

	spi_slave #(
		.CPOL (`SPI_CPOL),
		.CPHA (`SPI_CPHA)
	) spi_slave_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs_n      (cs_n),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.byte_io   (byte_io.slave)
	);

	spi_wb_bridge spi_wb_bridge_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_io   (byte_io.bridge),
		.wb        (wb.master)
	);

	spi_reg_file spi_reg_file_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wb        (wb.slave),
		.gpio_out  (gpio_out)
	);

endmodule

//--- hw/spi_reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Register bank on Wishbone classic, ack one cycle after stb.
// Register 0 is a fixed ID and ignores writes.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_reg_file (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	wb_reg_if.slave                wb,
	output logic [`SPI_DATA_W-1:0] gpio_out
);

	spi_pkg::reg_data_t regs [1:`SPI_NUM_REGS-1];  // no storage for the ID
	logic               req;
	logic               wr_en;

	assign req   = wb.cyc & wb.stb & ~wb.ack;     // first cycle of an access
	assign wr_en = req & wb.we & (wb.adr != '0);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			wb.ack <= 1'b0;
		else
			wb.ack <= req;
	end

	// only the gpio register comes out of reset cleared
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			regs[`SPI_GPIO_REG] <= '0;
		else if (wr_en)
			regs[wb.adr] <= wb.dat_w;
	end

	always_ff @(posedge sys_clk) begin
		if (req)
			wb.dat_r <= (wb.adr == '0) ? `SPI_DEV_ID : regs[wb.adr];
	end

	assign gpio_out = regs[`SPI_GPIO_REG];

endmodule

//--- hw/spi_wb_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Turns each two-byte SPI frame into one Wishbone classic access.
// Relies on the SCLK half period rule: a read fetch must finish before the
// first data bit shifts out, and no frame ends during a bus cycle.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_wb_bridge (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	spi_byte_if.bridge byte_io,
	wb_reg_if.master   wb
);

	typedef enum logic [2:0] {
		ST_IDLE,    // waiting for a command byte
		ST_CMD,     // write command seen, waiting for data byte
		ST_FETCH,   // read cycle on the bus
		ST_DATA,    // read data shifting out
		ST_STORE,   // write cycle on the bus
		ST_DONE     // ignore extra bytes until cs_n rises
	} state_t;

	state_t             state;
	spi_pkg::cmd_t      rx_cmd;
	spi_pkg::cmd_t      cmd;
	spi_pkg::reg_data_t wdata;
	logic               bus_req;
	logic               bus_we;
	logic               new_frame;

	assign rx_cmd    = spi_pkg::cmd_t'(byte_io.rx_data);
	assign new_frame = byte_io.rx_valid & byte_io.rx_first;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state   <= ST_IDLE;
			bus_req <= 1'b0;
			bus_we  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_frame) begin
						if (rx_cmd.write) begin
							state <= ST_CMD;
						end else begin
							bus_req <= 1'b1;    // read starts right away
							bus_we  <= 1'b0;
							state   <= ST_FETCH;
						end
					end
				end
				ST_CMD: begin
					if (byte_io.frame_end) begin
						state <= ST_IDLE;       // aborted, nothing written
					end else if (byte_io.rx_valid) begin
						bus_req <= 1'b1;
						bus_we  <= 1'b1;
						state   <= ST_STORE;
					end
				end
				ST_FETCH: begin
					if (wb.ack) begin
						bus_req <= 1'b0;
						state   <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (byte_io.frame_end)
						state <= ST_IDLE;
					else if (byte_io.rx_valid)
						state <= ST_DONE;
				end
				ST_STORE: begin
					if (wb.ack) begin
						bus_req <= 1'b0;
						bus_we  <= 1'b0;
						state   <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (byte_io.frame_end)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command and write data, held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && new_frame)
			cmd <= rx_cmd;
		if (state == ST_CMD && byte_io.rx_valid)
			wdata <= byte_io.rx_data;
	end

	// read value for the shifter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			byte_io.tx_data <= '0;
		else if (state == ST_FETCH && wb.ack)
			byte_io.tx_data <= wb.dat_r;
	end

	assign wb.cyc   = bus_req;
	assign wb.stb   = bus_req;
	assign wb.we    = bus_we;
	assign wb.adr   = cmd.addr;      // reserved bits dropped here
	assign wb.dat_w = wdata;

endmodule

//--- hw/spi_slave.sv
////////////////////////////////////////////////////////////////////////////
// SPI target shifter, all pins oversampled by sys_clk through 2 flops.
// SCLK must stay in each phase for several sys_clk cycles. With CPHA=0
// the first miso bit appears a few cycles after cs_n falls.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_slave #(
	parameter bit CPOL = 1'b1,    // sclk idle level
	parameter bit CPHA = 1'b1     // 1: shift on leading, sample on trailing
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       cs_n,
	input  logic       sclk,
	input  logic       mosi,
	output logic       miso,
	spi_byte_if.slave  byte_io
);

	localparam int CNT_W = $clog2(`SPI_DATA_W);

	logic [2:0]           cs_pipe;    // [0] meta, [1] sync, [2] edge reference
	logic [2:0]           sclk_pipe;
	logic [1:0]           mosi_pipe;

	logic                 cs_act;
	logic                 cs_fall;
	logic                 cs_rise;
	logic                 sclk_rise;
	logic                 sclk_fall;
	logic                 lead_edge;
	logic                 trail_edge;
	logic                 sample_evt;
	logic                 shift_evt;
	logic                 last_bit;

	logic [CNT_W-1:0]     bit_cnt;
	logic                 first_pend; // no byte seen yet in this frame
	spi_pkg::reg_data_t   rx_shift;
	spi_pkg::reg_data_t   tx_shift;

	// pin synchronizers
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_pipe   <= 3'b111;        // deselected
			sclk_pipe <= {3{CPOL}};
			mosi_pipe <= 2'b00;
		end else begin
			cs_pipe   <= {cs_pipe[1:0], cs_n};
			sclk_pipe <= {sclk_pipe[1:0], sclk};
			mosi_pipe <= {mosi_pipe[0], mosi};
		end
	end

	assign cs_act    = ~cs_pipe[1];
	assign cs_fall   = ~cs_pipe[1] & cs_pipe[2];
	assign cs_rise   = cs_pipe[1] & ~cs_pipe[2];
	assign sclk_rise = sclk_pipe[1] & ~sclk_pipe[2];
	assign sclk_fall = ~sclk_pipe[1] & sclk_pipe[2];

	// leading edge leaves the idle level
	assign lead_edge  = CPOL ? sclk_fall : sclk_rise;
	assign trail_edge = CPOL ? sclk_rise : sclk_fall;

	assign sample_evt = cs_act & (CPHA ? trail_edge : lead_edge);
	assign shift_evt  = cs_act & (CPHA ? lead_edge : trail_edge);
	assign last_bit   = (bit_cnt == CNT_W'(`SPI_DATA_W - 1));

	// bit position, dropped with cs so a partial byte is lost
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || !cs_act)
			bit_cnt <= '0;
		else if (sample_evt)
			bit_cnt <= bit_cnt + 1'b1;  // wraps at byte boundary
	end

	always_ff @(posedge sys_clk) begin
		if (sample_evt)
			rx_shift <= {rx_shift[`SPI_DATA_W-2:0], mosi_pipe[1]};
	end

	assign byte_io.rx_data = rx_shift;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			byte_io.rx_valid  <= 1'b0;
			byte_io.rx_first  <= 1'b0;
			byte_io.frame_end <= 1'b0;
			first_pend        <= 1'b0;
		end else begin
			byte_io.rx_valid  <= sample_evt & last_bit;
			byte_io.frame_end <= cs_rise;
			if (sample_evt && last_bit)
				byte_io.rx_first <= first_pend;
			if (cs_fall)
				first_pend <= 1'b1;
			else if (sample_evt && last_bit)
				first_pend <= 1'b0;
		end
	end

	// load at frame start for CPHA=0, then on the first shift edge of a byte
	always_ff @(posedge sys_clk) begin
		if (cs_fall || (shift_evt && bit_cnt == '0))
			tx_shift <= byte_io.tx_data;
		else if (shift_evt)
			tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
	end

	assign miso = cs_act & tx_shift[`SPI_DATA_W-1];  // low while deselected

endmodule

//--- hw/wb_reg_if.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic bus to the register file, one outstanding cycle only.
// No err, rty or byte selects; every access is a full register.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb_reg_if;

	logic               cyc;
	logic               stb;
	logic               we;
	spi_pkg::reg_addr_t adr;
	spi_pkg::reg_data_t dat_w;
	spi_pkg::reg_data_t dat_r;
	logic               ack;

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output dat_r,
		output ack
	);

endinterface

//--- hw/spi_byte_if.sv
////////////////////////////////////////////////////////////////////////////
// Byte handoff between the SPI shifter and the bus bridge. Strobes are
// single sys_clk pulses; tx_data must be steady before the next byte.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface spi_byte_if;

	logic               rx_valid;   // one pulse per full byte
	spi_pkg::reg_data_t rx_data;
	logic               rx_first;   // byte was the first of the frame
	logic               frame_end;  // one pulse when cs_n goes high
	spi_pkg::reg_data_t tx_data;    // next byte to return on miso

	modport slave (
		output rx_valid,
		output rx_data,
		output rx_first,
		output frame_end,
		input  tx_data
	);

	modport bridge (
		input  rx_valid,
		input  rx_data,
		input  rx_first,
		input  frame_end,
		output tx_data
	);

endinterface

//--- hw/spi_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the bridge, the register file and both interfaces.
// The command byte layout assumes SPI_DATA_W > SPI_ADDR_W + 1.
////////////////////////////////////////////////////////////////////////////
`include "spi_params.svh"

package spi_pkg;

	typedef logic [`SPI_ADDR_W-1:0] reg_addr_t;
	typedef logic [`SPI_DATA_W-1:0] reg_data_t;

	// first byte of every frame, sent msb first
	typedef struct packed {
		logic                                write;  // 1 write, 0 read
		logic [`SPI_DATA_W-`SPI_ADDR_W-2:0] rsvd;   // don't care
		reg_addr_t                           addr;
	} cmd_t;

endpackage

//--- hw/spi_params.svh
////////////////////////////////////////////////////////////////////////////
// Build constants for the SPI register target. The SPI master must keep
// every SCLK half period at least SPI_MIN_HALF_CYC sys_clk cycles long.
////////////////////////////////////////////////////////////////////////////
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

`define SPI_DATA_W        8       // byte and register width
`define SPI_ADDR_W        4       // register address bits in the command
`define SPI_NUM_REGS      16
`define SPI_DEV_ID        8'hA5   // read-only value of register 0
`define SPI_GPIO_REG      1       // register mirrored on gpio_out
`define SPI_MIN_HALF_CYC  8       // sclk half period floor, sys_clk cycles
`define SPI_CPOL          1'b1    // mode 3 by default
`define SPI_CPHA          1'b1

`endif
